// File: common/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define TLB_ENTRIES_NUM   16

// Cause.ExcCode values
`define EXCCODE_INT       5'd0
`define EXCCODE_MOD       5'd1
`define EXCCODE_TLBL      5'd2
`define EXCCODE_TLBS      5'd3
`define EXCCODE_ADEL      5'd4
`define EXCCODE_ADES      5'd5
`define EXCCODE_SYS       5'd8
`define EXCCODE_BP        5'd9
`define EXCCODE_RI        5'd10
`define EXCCODE_OV        5'd12

`define EXC_VECTOR_NORMAL 32'h0000_0180
`define EXC_BOOT_BASE     32'hBFC0_0200
`define STATUS_RESET      32'h1040_0000
`define EBASE_RESET       32'h8000_0000
`define PRID_VALUE        32'h0001_8000

`endif

// File: common/cpu_pkg.sv
package cpu_pkg;

	typedef logic [31:0] uint32_t;
	typedef logic [4:0]  reg_addr_t;

	typedef struct packed {
		uint32_t   we;     // only bit 0 is meaningful
		uint32_t   wsel;
		uint32_t   waddr;
		uint32_t   wdata;
	} cp0_req_t;

	typedef struct packed {
		logic [2:0] pad_31_29;
		logic       cu0;
		logic [4:0] pad_27_23;
		logic       bev;
		logic [5:0] pad_21_16;
		logic [7:0] im;
		logic [2:0] pad_7_5;
		logic       um;
		logic       pad_3;
		logic       erl;
		logic       exl;
		logic       ie;
	} status_t;

	typedef struct packed {
		logic       bd;
		logic [6:0] pad_30_24;
		logic       iv;
		logic [6:0] pad_22_16;
		logic [7:0] ip;
		logic       pad_7;
		logic [4:0] exc_code;
		logic [1:0] pad_1_0;
	} cause_t;

	typedef struct packed {
		uint32_t index, random, entry_lo0, entry_lo1;
		uint32_t context_, page_mask, wired, bad_vaddr;
		uint32_t count, entry_hi, compare;
		status_t status;
		cause_t  cause;
		uint32_t epc, ebase, config0, config1, prid;
	} cp0_regs_t;

	typedef struct packed {
		logic [18:0] vpn2;
		logic [7:0]  asid;
		logic        G;
		logic [19:0] pfn0;
		logic [2:0]  c0;
		logic        d0, v0;
		logic [19:0] pfn1;
		logic [2:0]  c1;
		logic        d1, v1;
	} tlb_entry_t;

	typedef struct packed {
		logic    valid;
		uint32_t pc;
		logic    delayslot, eret;
		logic    addr_err_load, addr_err_store;
		logic    tlb_load, tlb_store, tlb_mod;
		logic    syscall, brk, ri, ov;
		uint32_t bad_addr;
	} mem_except_t;

	typedef struct packed {
		logic       valid, eret, delayslot;
		uint32_t    pc;
		logic [4:0] code;
		uint32_t    extra;
	} except_req_t;

	typedef enum logic [1:0] {
		TLB_NONE,
		TLB_READ,
		TLB_PROBE,
		TLB_WRITE_RANDOM
	} tlb_op_t;

endpackage

// File: src/tlb.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module tlb (
	input  logic                clk,
	input  logic                rst,
	input  cpu_pkg::tlb_op_t    tlb_op,
	input  cpu_pkg::tlb_entry_t wdata,
	input  logic [3:0]          random_idx,
	input  logic [3:0]          read_idx,
	input  cpu_pkg::uint32_t    probe_hi,
	output cpu_pkg::tlb_entry_t rdata,
	output cpu_pkg::uint32_t    probe_res,
	input  cpu_pkg::uint32_t    lookup_vaddr,
	input  logic [7:0]          lookup_asid,
	output cpu_pkg::uint32_t    lookup_paddr,
	output logic                lookup_miss
);
	import cpu_pkg::*;

	localparam int N     = `TLB_ENTRIES_NUM;
	localparam int IDX_W = $clog2(N);

	tlb_entry_t       entries [N];
	logic [N-1:0]     valid_q;
	logic [IDX_W:0]   probe_find, lookup_find; // {hit, index}
	tlb_entry_t       lk_entry;
	logic             odd;

	// Fully associative search, the highest matching index wins
	function automatic logic [IDX_W:0] find(logic [18:0] vpn2, logic [7:0] asid);
		logic [IDX_W:0] res;
		res = '0;
		for (int i = 0; i < N; i++) begin
			if (valid_q[i] && entries[i].vpn2 == vpn2 && (entries[i].G || entries[i].asid == asid))
				res = {1'b1, IDX_W'(i)};
		end
		return res;
	endfunction

	always_ff @(posedge clk) begin
		if (rst)
			valid_q <= '0;
		else if (tlb_op == TLB_WRITE_RANDOM)
			valid_q[random_idx] <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (tlb_op == TLB_WRITE_RANDOM)
			entries[random_idx] <= wdata;
	end

	assign rdata = valid_q[read_idx] ? entries[read_idx] : '0;

	assign probe_find = find(probe_hi[31:13], probe_hi[7:0]);
	assign probe_res  = probe_find[IDX_W] ? {{(32-IDX_W){1'b0}}, probe_find[IDX_W-1:0]}
		: 32'h8000_0000;

	assign lookup_find  = find(lookup_vaddr[31:13], lookup_asid);
	assign lk_entry     = lookup_find[IDX_W] ? entries[lookup_find[IDX_W-1:0]] : '0;
	assign odd          = lookup_vaddr[12]; // Even/odd page of the pair
	assign lookup_paddr = {odd ? lk_entry.pfn1 : lk_entry.pfn0, lookup_vaddr[11:0]};
	assign lookup_miss  = ~lookup_find[IDX_W] | ~(odd ? lk_entry.v1 : lk_entry.v0);

endmodule

// File: src/except_arb.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module except_arb (
	input  cpu_pkg::mem_except_t mem_except,
	input  cpu_pkg::cp0_regs_t   regs,
	output cpu_pkg::except_req_t except_req,
	output logic                 redirect_valid,
	output cpu_pkg::uint32_t     redirect_pc
);
	import cpu_pkg::*;

	logic       int_pending;
	logic       take;
	logic [4:0] code;
	uint32_t    vec_base;

	assign int_pending = |(regs.cause.ip & regs.status.im) & regs.status.ie
		& ~regs.status.exl & ~regs.status.erl;

	always_comb begin
		take = 1'b1;
		code = `EXCCODE_INT;
		if (int_pending)
			code = `EXCCODE_INT;
		else if (mem_except.addr_err_load)
			code = `EXCCODE_ADEL; // Fetch or load
		else if (mem_except.ri)
			code = `EXCCODE_RI;
		else if (mem_except.ov)
			code = `EXCCODE_OV;
		else if (mem_except.syscall)
			code = `EXCCODE_SYS;
		else if (mem_except.brk)
			code = `EXCCODE_BP;
		else if (mem_except.tlb_load)
			code = `EXCCODE_TLBL;
		else if (mem_except.tlb_store)
			code = `EXCCODE_TLBS;
		else if (mem_except.tlb_mod)
			code = `EXCCODE_MOD;
		else if (mem_except.addr_err_store)
			code = `EXCCODE_ADES;
		else
			take = 1'b0;
	end

	assign except_req.valid     = mem_except.valid & (take | mem_except.eret);
	assign except_req.eret      = ~take & mem_except.eret;
	assign except_req.delayslot = mem_except.delayslot;
	assign except_req.pc        = mem_except.pc;
	assign except_req.code      = code;
	assign except_req.extra     = mem_except.bad_addr;

	assign vec_base       = regs.status.bev ? `EXC_BOOT_BASE : regs.ebase;
	assign redirect_valid = except_req.valid;
	assign redirect_pc    = except_req.eret ? regs.epc : vec_base + `EXC_VECTOR_NORMAL;

endmodule

// File: cp0/cp0_regs.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cp0_regs (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 flush,
	input  cpu_pkg::reg_addr_t   raddr,
	input  logic [2:0]           rsel,
	input  cpu_pkg::cp0_req_t    wreq,
	input  cpu_pkg::except_req_t except_req,
	input  logic [7:0]           interrupt_flag,
	input  cpu_pkg::tlb_op_t     tlb_op,
	input  cpu_pkg::tlb_entry_t  tlbr_res,
	input  cpu_pkg::uint32_t     tlbp_res,
	output cpu_pkg::tlb_entry_t  tlb_wdata,
	output cpu_pkg::uint32_t     rdata,
	output cpu_pkg::cp0_regs_t   regs,
	output logic [7:0]           asid,
	output logic                 user_mode,
	output logic                 timer_int
);
	import cpu_pkg::*;

	localparam int IDX_W = $clog2(`TLB_ENTRIES_NUM);
	localparam uint32_t CONFIG0_RESET = {1'b1, 21'b0, 3'd1, 4'b0, 3'd3}; // Standard TLB, kseg0 cached
	localparam uint32_t CONFIG1_RESET = {1'b0, 6'(`TLB_ENTRIES_NUM - 1), 25'b0};

	cp0_regs_t   regs_q, regs_d;
	except_req_t except_q;
	uint32_t     rdata_d;
	uint32_t     wdata;
	logic        wr0, wr1;

	assign regs      = regs_q;
	assign asid      = regs_q.entry_hi[7:0];
	assign user_mode = regs_q.status.um & ~regs_q.status.exl & ~regs_q.status.erl;
	assign wdata     = wreq.wdata;
	assign wr0       = wreq.we[0] && wreq.wsel == 32'd0;
	assign wr1       = wreq.we[0] && wreq.wsel == 32'd1;

	assign tlb_wdata.vpn2 = regs_q.entry_hi[31:13];
	assign tlb_wdata.asid = regs_q.entry_hi[7:0];
	assign tlb_wdata.G    = regs_q.entry_lo0[0] & regs_q.entry_lo1[0];
	assign tlb_wdata.pfn0 = regs_q.entry_lo0[25:6];
	assign tlb_wdata.c0   = regs_q.entry_lo0[5:3];
	assign tlb_wdata.d0   = regs_q.entry_lo0[2];
	assign tlb_wdata.v0   = regs_q.entry_lo0[1];
	assign tlb_wdata.pfn1 = regs_q.entry_lo1[25:6];
	assign tlb_wdata.c1   = regs_q.entry_lo1[5:3];
	assign tlb_wdata.d1   = regs_q.entry_lo1[2];
	assign tlb_wdata.v1   = regs_q.entry_lo1[1];

	// Exception is applied one edge after capture
	always_ff @(posedge clk) begin
		if (rst || flush)
			except_q <= '0;
		else
			except_q <= except_req;
	end

	always_comb begin
		rdata_d = '0;
		if (rsel == 3'd0) begin
			case (raddr)
				5'd0:  rdata_d = regs_q.index;
				5'd1:  rdata_d = regs_q.random;
				5'd2:  rdata_d = regs_q.entry_lo0;
				5'd3:  rdata_d = regs_q.entry_lo1;
				5'd4:  rdata_d = regs_q.context_;
				5'd5:  rdata_d = regs_q.page_mask;
				5'd6:  rdata_d = regs_q.wired;
				5'd8:  rdata_d = regs_q.bad_vaddr;
				5'd9:  rdata_d = regs_q.count;
				5'd10: rdata_d = regs_q.entry_hi;
				5'd11: rdata_d = regs_q.compare;
				5'd12: rdata_d = regs_q.status;
				5'd13: rdata_d = regs_q.cause;
				5'd14: rdata_d = regs_q.epc;
				5'd15: rdata_d = regs_q.prid;
				5'd16: rdata_d = regs_q.config0;
				default: rdata_d = '0;
			endcase
		end else if (rsel == 3'd1) begin
			if (raddr == 5'd15)
				rdata_d = regs_q.ebase;
			else if (raddr == 5'd16)
				rdata_d = regs_q.config1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			rdata <= '0;
		else
			rdata <= rdata_d;
	end

	always_ff @(posedge clk) begin
		if (rst)
			timer_int <= 1'b0;
		else if (wr0 && wreq.waddr == 32'd11)
			timer_int <= 1'b0; // Compare write acks the timer
		else if (regs_q.compare != '0 && regs_q.compare == regs_q.count)
			timer_int <= 1'b1;
	end

	always_comb begin
		regs_d = regs_q;
		regs_d.count = regs_q.count + 32'd1;
		regs_d.cause.ip[7:2] = interrupt_flag[7:2];

		if (tlb_op == TLB_WRITE_RANDOM) begin
			if (regs_q.random[IDX_W-1:0] == IDX_W'(`TLB_ENTRIES_NUM - 1))
				regs_d.random = regs_q.wired;
			else
				regs_d.random = regs_q.random + 32'd1;
		end

		if (wr0) begin
			case (wreq.waddr)
				32'd0:  regs_d.index = {{(32-IDX_W){1'b0}}, wdata[IDX_W-1:0]};
				32'd2:  regs_d.entry_lo0 = {6'b0, wdata[25:0]};
				32'd3:  regs_d.entry_lo1 = {6'b0, wdata[25:0]};
				32'd4:  regs_d.context_[31:23] = wdata[31:23];
				32'd6: begin
					regs_d.wired  = {{(32-IDX_W){1'b0}}, wdata[IDX_W-1:0]};
					regs_d.random = 32'(`TLB_ENTRIES_NUM - 1);
				end
				32'd9:  regs_d.count = wdata;
				32'd10: regs_d.entry_hi = {wdata[31:13], 5'b0, wdata[7:0]};
				32'd11: regs_d.compare = wdata;
				32'd12: begin
					regs_d.status.cu0 = wdata[28];
					regs_d.status.bev = wdata[22];
					regs_d.status.im  = wdata[15:8];
					regs_d.status.um  = wdata[4];
					regs_d.status.erl = wdata[2];
					regs_d.status.exl = wdata[1];
					regs_d.status.ie  = wdata[0];
				end
				32'd13: begin
					regs_d.cause.iv      = wdata[23];
					regs_d.cause.ip[1:0] = wdata[9:8]; // Software interrupts
				end
				32'd14: regs_d.epc = wdata;
				32'd16: regs_d.config0[2:0] = wdata[2:0];
				default: ;
			endcase
		end else if (wr1 && wreq.waddr == 32'd15) begin
			regs_d.ebase[29:12] = wdata[29:12];
		end

		if (tlb_op == TLB_READ) begin
			regs_d.entry_hi = {tlbr_res.vpn2, 5'b0, tlbr_res.asid};
			regs_d.entry_lo0 = {6'b0, tlbr_res.pfn0, tlbr_res.c0,
				tlbr_res.d0, tlbr_res.v0, tlbr_res.G};
			regs_d.entry_lo1 = {6'b0, tlbr_res.pfn1, tlbr_res.c1,
				tlbr_res.d1, tlbr_res.v1, tlbr_res.G};
		end else if (tlb_op == TLB_PROBE) begin
			regs_d.index = tlbp_res;
		end

		if (except_q.valid) begin
			if (except_q.eret) begin
				if (regs_d.status.erl)
					regs_d.status.erl = 1'b0;
				else
					regs_d.status.exl = 1'b0;
			end else begin
				if (!regs_d.status.exl) begin // Nested faults keep the first EPC
					regs_d.epc      = except_q.delayslot ? except_q.pc - 32'd4 : except_q.pc;
					regs_d.cause.bd = except_q.delayslot;
				end
				regs_d.status.exl     = 1'b1;
				regs_d.cause.exc_code = except_q.code;
				if (except_q.code == `EXCCODE_ADEL || except_q.code == `EXCCODE_ADES)
					regs_d.bad_vaddr = except_q.extra;
				if (except_q.code == `EXCCODE_TLBL || except_q.code == `EXCCODE_TLBS ||
						except_q.code == `EXCCODE_MOD) begin
					regs_d.bad_vaddr         = except_q.extra;
					regs_d.context_[22:4]    = except_q.extra[31:13]; // BadVPN2
					regs_d.entry_hi[31:13]   = except_q.extra[31:13];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			regs_q           <= '0;
			regs_q.random    <= 32'(`TLB_ENTRIES_NUM - 1);
			regs_q.status    <= `STATUS_RESET;
			regs_q.ebase     <= `EBASE_RESET;
			regs_q.config0   <= CONFIG0_RESET;
			regs_q.config1   <= CONFIG1_RESET;
			regs_q.prid      <= `PRID_VALUE;
		end else begin
			regs_q <= regs_d;
		end
	end

endmodule

// File: src/cp0_top.sv
`timescale 1ns/1ps

module cp0_top (
	input  logic                 clk,
	input  logic                 rst,
	input  cpu_pkg::mem_except_t mem_except,
	input  logic [7:0]           interrupt_flag,
	input  cpu_pkg::cp0_req_t    wreq,
	input  cpu_pkg::reg_addr_t   raddr,
	input  logic [2:0]           rsel,
	input  cpu_pkg::tlb_op_t     tlb_op,
	input  logic                 flush,
	input  cpu_pkg::uint32_t     lookup_vaddr,
	output cpu_pkg::uint32_t     rdata,
	output logic [7:0]           asid,
	output logic                 user_mode,
	output logic                 timer_int,
	output logic                 redirect_valid,
	output cpu_pkg::uint32_t     redirect_pc,
	output cpu_pkg::uint32_t     lookup_paddr,
	output logic                 lookup_miss
);
	import cpu_pkg::*;

	cp0_regs_t   regs;
	except_req_t except_req;
	tlb_entry_t  tlb_wdata, tlbr_res;
	uint32_t     tlbp_res;
	logic [7:0]  int_flags;

	assign int_flags = {interrupt_flag[7] | timer_int, interrupt_flag[6:0]}; // Timer on IP7

	except_arb u_arb (
		.mem_except     (mem_except),
		.regs           (regs),
		.except_req     (except_req),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc)
	);

	cp0_regs u_regs (
		.clk            (clk),
		.rst            (rst),
		.flush          (flush),
		.raddr          (raddr),
		.rsel           (rsel),
		.wreq           (wreq),
		.except_req     (except_req),
		.interrupt_flag (int_flags),
		.tlb_op         (tlb_op),
		.tlbr_res       (tlbr_res),
		.tlbp_res       (tlbp_res),
		.tlb_wdata      (tlb_wdata),
		.rdata          (rdata),
		.regs           (regs),
		.asid           (asid),
		.user_mode      (user_mode),
		.timer_int      (timer_int)
	);

	tlb u_tlb (
		.clk          (clk),
		.rst          (rst),
		.tlb_op       (tlb_op),
		.wdata        (tlb_wdata),
		.random_idx   (regs.random[3:0]),
		.read_idx     (regs.index[3:0]),
		.probe_hi     (regs.entry_hi),
		.rdata        (tlbr_res),
		.probe_res    (tlbp_res),
		.lookup_vaddr (lookup_vaddr),
		.lookup_asid  (asid),
		.lookup_paddr (lookup_paddr),
		.lookup_miss  (lookup_miss)
	);

endmodule

// File: dv/cp0_chk.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cp0_chk (
	input logic                 clk,
	input logic                 rst,
	input cpu_pkg::mem_except_t mem_except,
	input cpu_pkg::cp0_req_t    wreq,
	input logic                 timer_int,
	input logic                 redirect_valid,
	input cpu_pkg::uint32_t     redirect_pc,
	input cpu_pkg::uint32_t     rdata,
	input logic                 lookup_miss
);
	import cpu_pkg::*;

	int   fail_count = 0;
	logic compare_wr;
	logic exc_flag;

	assign compare_wr = wreq.we[0] && wreq.wsel == 32'd0 && wreq.waddr == 32'd11;
	assign exc_flag   = mem_except.addr_err_load | mem_except.addr_err_store | mem_except.ri
		| mem_except.ov | mem_except.syscall | mem_except.brk | mem_except.tlb_load
		| mem_except.tlb_store | mem_except.tlb_mod;

	rst_clear: assert property (@(posedge clk) rst |=> (rdata == '0 && !timer_int))
		else begin
			$error("registered outputs not clear after reset");
			fail_count++;
		end

	// Every entry is invalid after reset, so any address misses
	tlb_clear: assert property (@(posedge clk) rst |=> lookup_miss)
		else begin
			$error("TLB lookup hit right after reset");
			fail_count++;
		end

	compare_ack: assert property (@(posedge clk) disable iff (rst) compare_wr |=> !timer_int)
		else begin
			$error("timer_int still high after a compare write");
			fail_count++;
		end

	// Both vectors end in 0x180 in the low nine bits
	exc_vector: assert property (@(posedge clk) disable iff (rst)
		(mem_except.valid && exc_flag) |-> (redirect_valid && redirect_pc[8:0] == 9'h180))
		else begin
			$error("exception did not redirect to the exception vector");
			fail_count++;
		end

endmodule

bind cp0_top cp0_chk u_chk (.*);

// File: dv/tb_cp0.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module tb_cp0;
	import cpu_pkg::*;

	localparam int CLK_PERIOD   = 10;
	localparam int RESET_CYCLES = 10;
	localparam int TIMER_K      = 20;
	localparam int TIMER_LIMIT  = TIMER_K + 10;
	localparam int TEST_CYCLES  = RESET_CYCLES + 4 + (22 + RESET_CYCLES) + (4 + TIMER_LIMIT)
		+ 10 + 12 + (RESET_CYCLES + 30);
	localparam int WATCHDOG_NS  = 2 * TEST_CYCLES * CLK_PERIOD;

	localparam uint32_t     EXC_PC   = 32'h8000_1234;
	localparam uint32_t     BOOT_VEC = `EXC_BOOT_BASE + `EXC_VECTOR_NORMAL;
	localparam logic [18:0] VPN2     = 19'h12345;
	localparam logic [7:0]  ASID     = 8'h05;
	localparam logic [19:0] PFN0     = 20'hABCDE;
	localparam logic [19:0] PFN1     = 20'h13579;
	localparam uint32_t     ENTRY_HI = {VPN2, 5'b0, ASID};
	localparam uint32_t     LO0      = {6'b0, PFN0, 3'd3, 1'b1, 1'b1, 1'b0};
	localparam uint32_t     LO1      = {6'b0, PFN1, 3'd3, 1'b0, 1'b1, 1'b0};

	// Writable registers, their write masks and bits that stay fixed
	localparam reg_addr_t  MASK_ADDR [11] = '{5'd0, 5'd2, 5'd3, 5'd4, 5'd6, 5'd10,
		5'd11, 5'd12, 5'd13, 5'd14, 5'd15};
	localparam logic [2:0] MASK_SEL [11] = '{3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0,
		3'd0, 3'd0, 3'd0, 3'd0, 3'd1};
	localparam uint32_t    MASKS [11] = '{32'h0000_000F, 32'h03FF_FFFF, 32'h03FF_FFFF,
		32'hFF80_0000, 32'h0000_000F, 32'hFFFF_E0FF, 32'hFFFF_FFFF, 32'h1040_FF17,
		32'h0080_0300, 32'hFFFF_FFFF, 32'h3FFF_F000};
	localparam uint32_t    FIXED [11] = '{32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0,
		32'h0, 32'h0, 32'h0, 32'h0, `EBASE_RESET};

	logic        clk;
	logic        rst;
	mem_except_t mem_except;
	logic [7:0]  interrupt_flag;
	cp0_req_t    wreq;
	reg_addr_t   raddr;
	logic [2:0]  rsel;
	tlb_op_t     tlb_op;
	logic        flush;
	uint32_t     lookup_vaddr;
	uint32_t     rdata;
	logic [7:0]  asid;
	logic        user_mode;
	logic        timer_int;
	logic        redirect_valid;
	uint32_t     redirect_pc;
	uint32_t     lookup_paddr;
	logic        lookup_miss;

	integer seed = 18;
	int     errors = 0;
	int     test_errors = 0;
	int     tests_run = 0;
	int     tests_failed = 0;
	string  test_name;

	cp0_top DUT (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic reset_dut();
		rst = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;
	endtask

	task automatic write_reg(input reg_addr_t addr, input logic [2:0] sel, input uint32_t data);
		wreq.we    = 32'd1;
		wreq.wsel  = 32'(sel);
		wreq.waddr = 32'(addr);
		wreq.wdata = data;
		@(negedge clk);
		wreq = '0;
	endtask

	task automatic read_reg(input reg_addr_t addr, input logic [2:0] sel, output uint32_t data);
		raddr = addr;
		rsel  = sel;
		@(negedge clk); // rdata is one cycle behind raddr
		data = rdata;
	endtask

	task automatic check_word(input string what, input uint32_t expected, input uint32_t actual);
		assert (actual === expected)
		else begin
			$display("CHECK FAILED %s %s: expected %08h, actual %08h",
				test_name, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic read_check(input reg_addr_t addr, input logic [2:0] sel, input uint32_t mask,
			input uint32_t expected, input string what);
		uint32_t data;
		read_reg(addr, sel, data);
		check_word(what, expected & mask, data & mask);
	endtask

	task automatic pulse_tlb(input tlb_op_t op);
		tlb_op = op;
		@(negedge clk);
		tlb_op = TLB_NONE;
	endtask

	// Redirect is combinational, register effects land two edges later
	task automatic raise_exception(input mem_except_t me, input logic exp_valid,
			input uint32_t exp_pc);
		mem_except = me;
		#2;
		check_word("redirect valid", 32'(exp_valid), 32'(redirect_valid));
		if (exp_valid)
			check_word("redirect pc", exp_pc, redirect_pc);
		@(negedge clk);
		mem_except = '0;
		@(negedge clk);
	endtask

	task automatic finish_test();
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		$display("test %0d %s: %s", tests_run, test_name, test_errors == 0 ? "ok" : "FAILED");
		errors += test_errors;
		test_errors = 0;
	endtask

	initial begin
		uint32_t     data;
		uint32_t     got;
		mem_except_t me;
		int          cycles;

		rst            = 1'b1;
		mem_except     = '0;
		interrupt_flag = '0;
		wreq           = '0;
		raddr          = '0;
		rsel           = '0;
		tlb_op         = TLB_NONE;
		flush          = 1'b0;
		lookup_vaddr   = '0;
		reset_dut();

		test_name = "reset_values";
		read_check(5'd12, 3'd0, '1, `STATUS_RESET, "status");
		read_check(5'd1, 3'd0, '1, 32'(`TLB_ENTRIES_NUM - 1), "random");
		read_check(5'd15, 3'd0, '1, `PRID_VALUE, "prid");
		read_check(5'd15, 3'd1, '1, `EBASE_RESET, "ebase");
		finish_test();

		test_name = "write_masks";
		for (int i = 0; i < 11; i++) begin
			data = $random(seed);
			write_reg(MASK_ADDR[i], MASK_SEL[i], data);
			read_reg(MASK_ADDR[i], MASK_SEL[i], got);
			check_word($sformatf("reg %0d sel %0d", MASK_ADDR[i], MASK_SEL[i]),
				(data & MASKS[i]) | FIXED[i], got);
		end
		finish_test();
		reset_dut();

		test_name = "timer";
		write_reg(5'd9, 3'd0, 32'd0);
		write_reg(5'd11, 3'd0, 32'(TIMER_K));
		cycles = 0;
		while (!timer_int && cycles < TIMER_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (!timer_int) begin
			$display("timer interrupt never rose within %0d cycles", TIMER_LIMIT);
			test_errors++;
		end else begin
			check_word("cycles to timer_int", 32'(TIMER_K), 32'(cycles));
		end
		write_reg(5'd11, 3'd0, 32'd0);
		check_word("timer_int after compare write", 32'd0, 32'(timer_int));
		finish_test();

		test_name = "exception_eret";
		me           = '0;
		me.valid     = 1'b1;
		me.pc        = EXC_PC;
		me.delayslot = 1'b1;
		me.ri        = 1'b1;
		raise_exception(me, 1'b1, BOOT_VEC);
		read_check(5'd14, 3'd0, '1, EXC_PC - 32'd4, "epc");
		read_check(5'd13, 3'd0, 32'h8000_007C, 32'h8000_0000 | (32'(`EXCCODE_RI) << 2), "cause");
		read_check(5'd12, 3'd0, 32'h2, 32'h2, "status exl set");
		me       = '0;
		me.valid = 1'b1;
		me.eret  = 1'b1;
		me.pc    = BOOT_VEC;
		raise_exception(me, 1'b1, EXC_PC - 32'd4);
		read_check(5'd12, 3'd0, 32'h2, 32'h0, "status exl clear");
		finish_test();

		test_name = "interrupt";
		write_reg(5'd12, 3'd0, `STATUS_RESET | 32'h0000_0811); // IM[3], UM and IE
		check_word("user mode", 32'd1, 32'(user_mode));
		interrupt_flag = 8'h08;
		@(negedge clk);
		me       = '0;
		me.valid = 1'b1;
		me.pc    = EXC_PC + 32'd8;
		raise_exception(me, 1'b1, BOOT_VEC);
		read_check(5'd13, 3'd0, 32'h0000_007C, 32'(`EXCCODE_INT) << 2, "cause code");
		read_check(5'd12, 3'd0, 32'h2, 32'h2, "status exl set");
		check_word("user mode under EXL", 32'd0, 32'(user_mode));
		raise_exception(me, 1'b0, 32'd0); // Masked while EXL is set
		interrupt_flag = '0;
		write_reg(5'd12, 3'd0, `STATUS_RESET);
		finish_test();

		test_name = "tlb_round_trip";
		reset_dut();
		write_reg(5'd10, 3'd0, ENTRY_HI);
		check_word("asid", 32'(ASID), 32'(asid));
		write_reg(5'd2, 3'd0, LO0);
		write_reg(5'd3, 3'd0, LO1);
		pulse_tlb(TLB_WRITE_RANDOM);
		lookup_vaddr = {VPN2, 1'b0, 12'h345};
		@(negedge clk);
		check_word("even page paddr", {PFN0, 12'h345}, lookup_paddr);
		check_word("even page miss", 32'd0, 32'(lookup_miss));
		lookup_vaddr = {VPN2, 1'b1, 12'h678};
		@(negedge clk);
		check_word("odd page paddr", {PFN1, 12'h678}, lookup_paddr);
		check_word("odd page miss", 32'd0, 32'(lookup_miss));
		lookup_vaddr = {VPN2 ^ 19'h1, 1'b0, 12'h000};
		@(negedge clk);
		check_word("absent page miss", 32'd1, 32'(lookup_miss));
		pulse_tlb(TLB_PROBE);
		read_check(5'd0, 3'd0, '1, 32'(`TLB_ENTRIES_NUM - 1), "probe index");
		write_reg(5'd10, 3'd0, {VPN2 ^ 19'h1, 5'b0, ASID});
		pulse_tlb(TLB_PROBE);
		read_check(5'd0, 3'd0, 32'h8000_0000, 32'h8000_0000, "probe miss bit");
		write_reg(5'd10, 3'd0, 32'd0);
		write_reg(5'd0, 3'd0, 32'(`TLB_ENTRIES_NUM - 1));
		pulse_tlb(TLB_READ);
		read_check(5'd10, 3'd0, '1, ENTRY_HI, "entry_hi restored");
		read_check(5'd2, 3'd0, '1, LO0, "entry_lo0 restored");
		finish_test();

		errors += DUT.u_chk.fail_count;
		$display("tests run %0d, tests failed %0d, assertion failures %0d",
			tests_run, tests_failed, DUT.u_chk.fail_count);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
		$display("Test failed");
		$finish;
	end

endmodule

// File: flist.f
+incdir+common
common/cpu_pkg.sv
src/tlb.sv
src/except_arb.sv
cp0/cp0_regs.sv
src/cp0_top.sv
dv/cp0_chk.sv
dv/tb_cp0.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cp0
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SIMFLAGS  ?= +verilator+error+limit+100
PASS_MSG  := Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS SIMFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
